// ==== design/dma_wr_pkg.sv ====
// shared widths, AXI attribute codes, burst limits and types for the write DMA; import in each block
package dma_wr_pkg;

    ////////////////////////////////////////////////////////////////////
    // datapath sizing
    ////////////////////////////////////////////////////////////////////
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int ADDR_WIDTH = 16;
    localparam int LEN_WIDTH = 20;
    localparam int BEAT_SHIFT = $clog2(STRB_WIDTH);

    // burst limits
    localparam int MAX_BURST_LEN = 16;
    localparam int MAX_BURST_BYTES = MAX_BURST_LEN * STRB_WIDTH;
    localparam int BOUNDARY_BYTES = 4096;
    localparam int STATUS_FIFO_DEPTH = 32;

    // fixed AW attributes: INCR, modifiable bufferable, unprivileged non-secure data
    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [3:0] CACHE_ATTR = 4'b0011;
    localparam logic [2:0] PROT_ATTR = 3'b010;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [LEN_WIDTH-1:0] len_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_WRITE
    } seq_state_e;

endpackage

// ==== design/w_beat_if.sv ====
// write beat channel from the sequencer to the W skid buffer, with an early ready back
`timescale 1ns/1ps

interface w_beat_if;
    import dma_wr_pkg::*;

    data_t data;
    logic  last;
    logic  valid;
    // high when the skid buffer can take a beat on the next cycle
    logic  ready_early;

    modport source (
        output data, last, valid,
        input  ready_early
    );

    modport sink (
        input  data, last, valid,
        output ready_early
    );

endinterface

// ==== design/write_sequencer.sv ====
// descriptor intake and burst splitter; issues AW and hands stream words to the W path
`timescale 1ns/1ps

module write_sequencer (
    input  logic              aclk,
    input  logic              aresetn,
    input  dma_wr_pkg::addr_t desc_addr,
    input  dma_wr_pkg::len_t  desc_len,
    input  logic              desc_valid,
    output logic              desc_ready,
    input  dma_wr_pkg::data_t wr_data_tdata,
    input  logic              wr_data_tvalid,
    output logic              wr_data_tready,
    output dma_wr_pkg::addr_t awaddr,
    output logic [7:0]        awlen,
    output logic              awvalid,
    input  logic              awready,
    output logic              burst_push,
    output logic              burst_last,
    w_beat_if.source          beat
);
    import dma_wr_pkg::*;

    seq_state_e state_reg, state_next;

    addr_t      addr_reg, addr_next;
    len_t       remain_reg, remain_next;
    logic [7:0] beat_cnt_reg, beat_cnt_next;
    logic       last_burst_reg, last_burst_next;
    logic       first_reg, first_next;
    logic       desc_ready_reg, desc_ready_next;
    logic       tready_reg, tready_next;
    addr_t      awaddr_reg, awaddr_next;
    logic [7:0] awlen_reg, awlen_next;
    logic       awvalid_reg, awvalid_next;
    logic       ready_int_reg;

    len_t       tr_bytes;
    len_t       tr_beats;
    len_t       boundary_dist;
    logic       beat_fire;

    assign desc_ready = desc_ready_reg;
    assign wr_data_tready = tready_reg;
    assign awaddr = awaddr_reg;
    assign awlen = awlen_reg;
    assign awvalid = awvalid_reg;

    assign beat_fire = (state_reg == SEQ_WRITE) && ready_int_reg && tready_reg && wr_data_tvalid;
    assign beat.data = wr_data_tdata;
    assign beat.last = (beat_cnt_reg == 8'd0);
    assign beat.valid = beat_fire;

    // final beat of a burst queues it for the B response
    assign burst_push = beat_fire && (beat_cnt_reg == 8'd0);
    assign burst_last = last_burst_reg;

    ////////////////////////////////////////////////////////////////////
    // burst sizing
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        boundary_dist = len_t'(BOUNDARY_BYTES) - (len_t'(addr_reg) & len_t'(BOUNDARY_BYTES - 1));
        tr_bytes = remain_reg;
        if (tr_bytes > len_t'(MAX_BURST_BYTES)) begin
            tr_bytes = len_t'(MAX_BURST_BYTES);
        end
        // never run past the next 4 KB page
        if (tr_bytes > boundary_dist) begin
            tr_bytes = boundary_dist;
        end
        tr_beats = tr_bytes >> BEAT_SHIFT;
    end

    ////////////////////////////////////////////////////////////////////
    // sequencer FSM
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        state_next = state_reg;
        addr_next = addr_reg;
        remain_next = remain_reg;
        beat_cnt_next = beat_cnt_reg;
        last_burst_next = last_burst_reg;
        first_next = first_reg;
        desc_ready_next = 1'b0;
        tready_next = 1'b0;
        awaddr_next = awaddr_reg;
        awlen_next = awlen_reg;
        awvalid_next = awvalid_reg && !awready;

        case (state_reg)
            SEQ_IDLE: begin
                desc_ready_next = 1'b1;
                addr_next = desc_addr;
                remain_next = desc_len;
                first_next = 1'b1;
                if (desc_ready_reg && desc_valid) begin
                    desc_ready_next = 1'b0;
                    state_next = SEQ_START;
                end
            end
            SEQ_START: begin
                // wait for the previous AW to be taken before issuing the next
                if (!awvalid_reg) begin
                    awaddr_next = addr_reg;
                    awlen_next = 8'(tr_beats - 1'b1);
                    awvalid_next = wr_data_tvalid || !first_reg;
                    if (awvalid_next) begin
                        addr_next = addr_reg + addr_t'(tr_bytes);
                        remain_next = remain_reg - tr_bytes;
                        beat_cnt_next = 8'(tr_beats - 1'b1);
                        last_burst_next = (tr_bytes == remain_reg);
                        tready_next = beat.ready_early;
                        state_next = SEQ_WRITE;
                    end
                end
            end
            SEQ_WRITE: begin
                tready_next = beat.ready_early;
                if (beat_fire) begin
                    first_next = 1'b0;
                    beat_cnt_next = beat_cnt_reg - 8'd1;
                    if (beat_cnt_reg == 8'd0) begin
                        tready_next = 1'b0;
                        if (last_burst_reg) begin
                            desc_ready_next = 1'b1;
                            state_next = SEQ_IDLE;
                        end else begin
                            state_next = SEQ_START;
                        end
                    end
                end
            end
            default: begin
                state_next = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_reg <= SEQ_IDLE;
            desc_ready_reg <= 1'b0;
            tready_reg <= 1'b0;
            awvalid_reg <= 1'b0;
            ready_int_reg <= 1'b0;
            beat_cnt_reg <= 8'd0;
            last_burst_reg <= 1'b0;
            first_reg <= 1'b0;
        end else begin
            state_reg <= state_next;
            desc_ready_reg <= desc_ready_next;
            tready_reg <= tready_next;
            awvalid_reg <= awvalid_next;
            ready_int_reg <= beat.ready_early;
            beat_cnt_reg <= beat_cnt_next;
            last_burst_reg <= last_burst_next;
            first_reg <= first_next;
        end
        addr_reg <= addr_next;
        remain_reg <= remain_next;
        awaddr_reg <= awaddr_next;
        awlen_reg <= awlen_next;
    end

endmodule

// ==== design/w_skid_buffer.sv ====
// two-entry register stage on the AXI W channel that absorbs wready stalls
`timescale 1ns/1ps

module w_skid_buffer (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              wready,
    w_beat_if.sink            beat,
    output dma_wr_pkg::data_t wdata,
    output logic              wlast,
    output logic              wvalid
);
    import dma_wr_pkg::*;

    data_t out_data;
    logic  out_last;
    logic  out_valid, out_valid_next;
    data_t tmp_data;
    logic  tmp_last;
    logic  tmp_valid, tmp_valid_next;

    logic  in_to_out;
    logic  in_to_tmp;
    logic  tmp_to_out;

    assign wdata = out_data;
    assign wlast = out_last;
    assign wvalid = out_valid;

    // room next cycle if the output drains now, or the temp slot stays free
    assign beat.ready_early = wready || (!tmp_valid && (!out_valid || !beat.valid));

    always_comb begin
        out_valid_next = out_valid;
        tmp_valid_next = tmp_valid;
        in_to_out = 1'b0;
        in_to_tmp = 1'b0;
        tmp_to_out = 1'b0;

        if (beat.valid) begin
            if (wready || !out_valid) begin
                out_valid_next = 1'b1;
                in_to_out = 1'b1;
            end else begin
                tmp_valid_next = 1'b1;
                in_to_tmp = 1'b1;
            end
        end else if (wready) begin
            out_valid_next = tmp_valid;
            tmp_valid_next = 1'b0;
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            out_valid <= 1'b0;
            tmp_valid <= 1'b0;
        end else begin
            out_valid <= out_valid_next;
            tmp_valid <= tmp_valid_next;
        end

        if (in_to_out) begin
            out_data <= beat.data;
            out_last <= beat.last;
        end else if (tmp_to_out) begin
            out_data <= tmp_data;
            out_last <= tmp_last;
        end

        if (in_to_tmp) begin
            tmp_data <= beat.data;
            tmp_last <= beat.last;
        end
    end

endmodule

// ==== design/completion_fifo.sv ====
// queue of issued bursts; matches each B response and flags descriptor completion
`timescale 1ns/1ps

module completion_fifo (
    input  logic aclk,
    input  logic aresetn,
    input  logic burst_push,
    input  logic burst_last,
    input  logic bvalid,
    output logic bready,
    output logic desc_status_valid
);
    import dma_wr_pkg::*;

    // one flag per outstanding burst, set on the final burst of a descriptor
    logic last_mem [STATUS_FIFO_DEPTH];

    // extra wrap bit tells a full queue from an empty one
    logic [$clog2(STATUS_FIFO_DEPTH):0] wr_ptr;
    logic [$clog2(STATUS_FIFO_DEPTH):0] rd_ptr;
    logic                               not_empty;
    logic                               b_fire;

    assign not_empty = (wr_ptr != rd_ptr);
    assign b_fire = bready && bvalid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            bready <= 1'b0;
            desc_status_valid <= 1'b0;
        end else begin
            desc_status_valid <= 1'b0;
            if (burst_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // bready drops for a cycle after every response
            bready <= not_empty && !b_fire;
            if (not_empty && b_fire) begin
                desc_status_valid <= last_mem[rd_ptr[$clog2(STATUS_FIFO_DEPTH)-1:0]];
                rd_ptr <= rd_ptr + 1'b1;
            end
        end

        if (burst_push) begin
            last_mem[wr_ptr[$clog2(STATUS_FIFO_DEPTH)-1:0]] <= burst_last;
        end
    end

endmodule

// ==== design/axi_dma_wr.sv ====
// AXI4 write DMA top level; connects a descriptor and stream input to an AXI master write port
`timescale 1ns/1ps

module axi_dma_wr (
    input  logic                              aclk,
    input  logic                              aresetn,

    // descriptor in
    input  dma_wr_pkg::addr_t                 desc_addr,
    input  dma_wr_pkg::len_t                  desc_len,
    input  logic                              desc_valid,
    output logic                              desc_ready,

    // completion status
    output logic                              desc_status_valid,

    // stream data in
    input  dma_wr_pkg::data_t                 wr_data_tdata,
    input  logic                              wr_data_tvalid,
    output logic                              wr_data_tready,

    // AXI master write channels
    output logic                              awid,
    output dma_wr_pkg::addr_t                 awaddr,
    output logic [7:0]                        awlen,
    output logic [2:0]                        awsize,
    output logic [1:0]                        awburst,
    output logic                              awlock,
    output logic [3:0]                        awcache,
    output logic [2:0]                        awprot,
    output logic                              awvalid,
    input  logic                              awready,
    output dma_wr_pkg::data_t                 wdata,
    output logic [dma_wr_pkg::STRB_WIDTH-1:0] wstrb,
    output logic                              wlast,
    output logic                              wvalid,
    input  logic                              wready,
    input  logic                              bvalid,
    output logic                              bready
);
    import dma_wr_pkg::*;

    logic burst_push;
    logic burst_last;

    w_beat_if beat ();

    //////////////////////////////////////////////////////////////////////
    // constant AW attributes, full-word strobes
    //////////////////////////////////////////////////////////////////////
    assign awid = 1'b0;
    assign awsize = 3'(BEAT_SHIFT);
    assign awburst = BURST_INCR;
    assign awlock = 1'b0;
    assign awcache = CACHE_ATTR;
    assign awprot = PROT_ATTR;
    assign wstrb = '1;

    write_sequencer u_sequencer (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .desc_addr      (desc_addr),
        .desc_len       (desc_len),
        .desc_valid     (desc_valid),
        .desc_ready     (desc_ready),
        .wr_data_tdata  (wr_data_tdata),
        .wr_data_tvalid (wr_data_tvalid),
        .wr_data_tready (wr_data_tready),
        .awaddr         (awaddr),
        .awlen          (awlen),
        .awvalid        (awvalid),
        .awready        (awready),
        .burst_push     (burst_push),
        .burst_last     (burst_last),
        .beat           (beat.source)
    );

    w_skid_buffer u_skid (
        .aclk    (aclk),
        .aresetn (aresetn),
        .wready  (wready),
        .beat    (beat.sink),
        .wdata   (wdata),
        .wlast   (wlast),
        .wvalid  (wvalid)
    );

    completion_fifo u_completion (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .burst_push        (burst_push),
        .burst_last        (burst_last),
        .bvalid            (bvalid),
        .bready            (bready),
        .desc_status_valid (desc_status_valid)
    );

endmodule

// ==== sim/axi_dma_wr_properties.sv ====
// handshake stability checks for the write DMA AXI channels; bound into the top level
`timescale 1ns/1ps

module axi_dma_wr_properties (
    input logic              aclk,
    input logic              aresetn,
    input dma_wr_pkg::addr_t awaddr,
    input logic [7:0]        awlen,
    input logic              awvalid,
    input logic              awready,
    input dma_wr_pkg::data_t wdata,
    input logic              wlast,
    input logic              wvalid,
    input logic              wready,
    input logic              desc_status_valid
);

    // AW payload holds until the slave takes it
    aw_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr) && $stable(awlen)))
        else $error("AW dropped or changed while stalled");

    // same for the W beat under wready back-pressure
    w_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (wvalid && !wready) |=> (wvalid && $stable(wdata) && $stable(wlast)))
        else $error("W beat dropped or changed while stalled");

    status_single: assert property (@(posedge aclk) disable iff (!aresetn)
        desc_status_valid |=> !desc_status_valid)
        else $error("status pulse longer than one cycle");

endmodule

bind axi_dma_wr axi_dma_wr_properties u_properties (
    .aclk              (aclk),
    .aresetn           (aresetn),
    .awaddr            (awaddr),
    .awlen             (awlen),
    .awvalid           (awvalid),
    .awready           (awready),
    .wdata             (wdata),
    .wlast             (wlast),
    .wvalid            (wvalid),
    .wready            (wready),
    .desc_status_valid (desc_status_valid)
);

// ==== sim/axi_dma_wr_tb.sv ====
// table-driven testbench for the AXI4 write DMA; simulation top, compiled through the file list
`timescale 1ns/1ps

module axi_dma_wr_tb;
    import dma_wr_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_ROWS = 8;

    typedef struct packed {
        logic [15:0] addr;
        logic [19:0] len;
        logic [7:0]  aw_stall;
        logic [7:0]  w_stall;
        logic [7:0]  b_stall;
    } row_t;

    logic                  aclk;
    logic                  aresetn;
    addr_t                 desc_addr;
    len_t                  desc_len;
    logic                  desc_valid;
    logic                  desc_ready;
    logic                  desc_status_valid;
    data_t                 wr_data_tdata;
    logic                  wr_data_tvalid;
    logic                  wr_data_tready;
    logic                  awid;
    addr_t                 awaddr;
    logic [7:0]            awlen;
    logic [2:0]            awsize;
    logic [1:0]            awburst;
    logic                  awlock;
    logic [3:0]            awcache;
    logic [2:0]            awprot;
    logic                  awvalid;
    logic                  awready;
    data_t                 wdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic                  wlast;
    logic                  wvalid;
    logic                  wready;
    logic                  bvalid;
    logic                  bready;

    row_t  table_rows [NUM_ROWS];
    addr_t exp_addr [$];
    int    exp_beats [$];
    logic  exp_last [$];
    data_t word_base = '0;
    int    words_total = 0;
    int    words_sent = 0;
    int    aw_seen = 0;
    int    w_seen = 0;
    int    wlast_seen = 0;
    int    b_issued = 0;
    int    b_done = 0;
    int    pulses = 0;
    int    stall_aw = 0;
    int    stall_w = 0;
    int    stall_b = 0;
    int    errors = 0;
    int    rows_failed = 0;

    axi_dma_wr dut (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // columns: address, byte length, then awready, wready and bvalid stall percent
    task automatic load_table();
        table_rows[0] = '{16'h0000, 20'd16, 8'd0, 8'd0, 8'd0};
        table_rows[1] = '{16'h0100, 20'd64, 8'd0, 8'd0, 8'd0};
        table_rows[2] = '{16'h0200, 20'd200, 8'd10, 8'd10, 8'd10};
        table_rows[3] = '{16'h0FF0, 20'd96, 8'd0, 8'd20, 8'd0};
        table_rows[4] = '{16'h1FC8, 20'd128, 8'd20, 8'd0, 8'd20};
        table_rows[5] = '{16'h2F00, 20'd320, 8'd60, 8'd60, 8'd60};
        table_rows[6] = '{16'h3FF8, 20'd24, 8'd30, 8'd30, 8'd30};
        table_rows[7] = '{16'h4000, 20'd4, 8'd50, 8'd50, 8'd50};
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic flag_failure(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    function automatic bit stalled(input int pct);
        return int'($urandom % 100) < pct;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // expected burst split: up to 64 bytes, never across a 4 KB page
    ////////////////////////////////////////////////////////////////////
    task automatic build_expected(input addr_t start, input int len);
        int    remain;
        int    bytes;
        int    page_room;
        int    i;
        addr_t addr;
        exp_addr.delete();
        exp_beats.delete();
        exp_last.delete();
        remain = len;
        addr = start;
        while (remain > 0) begin
            bytes = (remain < 64) ? remain : 64;
            page_room = 4096 - (int'(addr) % 4096);
            if (bytes > page_room) begin
                bytes = page_room;
            end
            exp_addr.push_back(addr);
            exp_beats.push_back(bytes / 4);
            for (i = 0; i < bytes / 4; i++) begin
                exp_last.push_back(i == bytes / 4 - 1);
            end
            addr = addr + addr_t'(bytes);
            remain = remain - bytes;
        end
    endtask

    task automatic record_aw();
        if (aw_seen >= exp_addr.size()) begin
            flag_failure("AW burst beyond the expected split");
        end else begin
            check_value("awaddr", 32'(awaddr), 32'(exp_addr[aw_seen]));
            check_value("awlen", 32'(awlen), 32'(exp_beats[aw_seen] - 1));
            // id 0, 4-byte beats, INCR, no lock, modifiable bufferable, unprivileged data
            check_value("aw attributes", 32'({awid, awsize, awburst, awlock, awcache, awprot}),
                        32'({1'b0, 3'd2, 2'b01, 1'b0, 4'b0011, 3'b010}));
        end
        aw_seen++;
    endtask

    task automatic record_w();
        if (w_seen >= words_total) begin
            flag_failure("W beat beyond the descriptor length");
        end else begin
            check_value("wdata", wdata, word_base + data_t'(w_seen));
            check_value("wstrb", 32'(wstrb), 32'hf);
            check_value("wlast", 32'(wlast), 32'(exp_last[w_seen]));
        end
        if (wlast) begin
            wlast_seen++;
        end
        w_seen++;
    endtask

    ////////////////////////////////////////////////////////////////////
    // stream source and AXI slave model
    ////////////////////////////////////////////////////////////////////
    initial begin : slave_model
        logic b_taken;
        b_taken = 1'b0;
        void'($urandom(24004));
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        wr_data_tvalid = 1'b0;
        wr_data_tdata = '0;
        forever begin
            @(posedge aclk);
            #1;
            awready = !stalled(stall_aw);
            wready = !stalled(stall_w);
            if (b_taken) begin
                bvalid = 1'b0;
                b_taken = 1'b0;
            end
            // a burst is answered once its AW and its wlast have both gone by
            if (!bvalid && b_issued < aw_seen && b_issued < wlast_seen && !stalled(stall_b)) begin
                bvalid = 1'b1;
                b_issued++;
            end
            wr_data_tvalid = (words_sent < words_total);
            wr_data_tdata = word_base + data_t'(words_sent);

            // sample mid-cycle, where everything seen by the next edge is settled
            @(negedge aclk);
            if (wr_data_tvalid && wr_data_tready) begin
                words_sent++;
            end
            if (awvalid && awready) begin
                record_aw();
            end
            if (wvalid && wready) begin
                record_w();
            end
            if (bvalid && bready) begin
                b_done++;
                b_taken = 1'b1;
            end
            if (desc_status_valid) begin
                pulses++;
                if (b_done != exp_addr.size()) begin
                    flag_failure("status pulse came before the final B response");
                end
            end
        end
    end

    task automatic run_row(input int r);
        int   start_errors;
        logic taken;
        start_errors = errors;
        @(posedge aclk);
        build_expected(table_rows[r].addr, int'(table_rows[r].len));
        stall_aw = int'(table_rows[r].aw_stall);
        stall_w = int'(table_rows[r].w_stall);
        stall_b = int'(table_rows[r].b_stall);
        word_base = data_t'(r + 1) << 24;
        words_total = int'(table_rows[r].len) / 4;
        words_sent = 0;
        aw_seen = 0;
        w_seen = 0;
        wlast_seen = 0;
        b_issued = 0;
        b_done = 0;
        pulses = 0;
        #1;
        desc_addr = table_rows[r].addr;
        desc_len = table_rows[r].len;
        desc_valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge aclk);
            taken = desc_ready;
        end
        @(posedge aclk);
        #1;
        desc_valid = 1'b0;
        while (pulses == 0) begin
            @(posedge aclk);
        end
        // a second pulse or a stray beat would land in this window
        repeat (4) @(posedge aclk);
        check_value("AW bursts", aw_seen, exp_addr.size());
        check_value("W beats", w_seen, words_total);
        check_value("B responses", b_done, exp_addr.size());
        check_value("status pulses", pulses, 1);
        if (errors == start_errors) begin
            $display("row %0d addr 0x%04h len %0d: %0d bursts, passed",
                     r, table_rows[r].addr, table_rows[r].len, exp_addr.size());
        end else begin
            rows_failed++;
            $display("row %0d addr 0x%04h len %0d: failed",
                     r, table_rows[r].addr, table_rows[r].len);
        end
    endtask

    initial begin : main_sequence
        int ready_wait;
        int r;
        load_table();
        aresetn = 1'b0;
        desc_addr = '0;
        desc_len = '0;
        desc_valid = 1'b0;
        repeat (5) @(posedge aclk);
        #1;
        check_value("outputs in reset",
                    32'({desc_ready, wr_data_tready, awvalid, wvalid, bready, desc_status_valid}), 0);
        aresetn = 1'b1;
        ready_wait = 0;
        while (!desc_ready && ready_wait < 4) begin
            @(posedge aclk);
            #1;
            ready_wait++;
        end
        if (!desc_ready) begin
            flag_failure("desc_ready did not rise after reset");
        end
        check_value("outputs after reset", 32'({awvalid, wvalid, bready, desc_status_valid}), 0);

        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("rows run %0d, rows failed %0d, errors %0d", NUM_ROWS, rows_failed, errors);
        if (errors == 0 && rows_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // limit grows with the words in the table
    initial begin : watchdog
        int limit_cycles;
        int r;
        #1;
        limit_cycles = 20;
        for (r = 0; r < NUM_ROWS; r++) begin
            limit_cycles += (int'(table_rows[r].len) / 4 + 1) * 200;
        end
        repeat (limit_cycles) @(posedge aclk);
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== axi_dma_wr.f ====
design/dma_wr_pkg.sv
design/w_beat_if.sv
design/write_sequencer.sv
design/w_skid_buffer.sv
design/completion_fifo.sv
design/axi_dma_wr.sv
sim/axi_dma_wr_properties.sv
sim/axi_dma_wr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f axi_dma_wr.f \
    --top-module axi_dma_wr_tb -o axi_dma_wr_sim || exit 1

out=$(./obj_dir/axi_dma_wr_sim)
echo "$out"
echo "$out" | grep -qx "Everything OK" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
